// ==== design/rv_mem_pkg.sv ====
/*
 * rv_mem_pkg
 *   widths, IO region and load/store size codes for the memory back end
 */

package rv_mem_pkg;

	// data path width
	localparam int xlen = 32;

	// RAM word address covers byte address bits 13..2
	localparam int ram_aw = 12;

	// IO word address covers byte address bits 11..2
	localparam int io_aw = 10;

	// register file address
	localparam int reg_aw = 5;

	// address bits 31..30 of a store that goes to the IO port
	localparam logic [1:0] io_region = 2'b11;

	// RISC-V funct3 size codes for loads and stores
	typedef enum logic [2:0] {
		ls_b  = 3'd0,
		ls_h  = 3'd1,
		ls_w  = 3'd2,
		ls_bu = 3'd4,
		ls_hu = 3'd5
	} ldst_code_e;

endpackage

// ==== design/store_align.sv ====
/*
 * store_align
 *   moves store data to its byte lanes, builds byte enables, splits memory and IO
 */

module store_align (
	input  logic                         cmd_st,
	input  rv_mem_pkg::ldst_code_e       ldst_code,
	input  logic [rv_mem_pkg::xlen-1:0]  adr,
	input  logic [rv_mem_pkg::xlen-1:0]  st_data,
	output logic [rv_mem_pkg::xlen-1:0]  st_wdata,
	output logic [3:0]                   st_we_mem,
	output logic [3:0]                   st_we_io
);
	import rv_mem_pkg::*;

	logic [3:0] lane_be;
	logic [3:0] st_we;
	logic       is_io;

	// lane placement by size and low address bits
	always_comb begin
		case (ldst_code)
			ls_b: begin
				st_wdata = xlen'(st_data[7:0]) << {adr[1:0], 3'b000};
				lane_be  = 4'b0001 << adr[1:0];
			end
			ls_h: begin
				st_wdata = xlen'(st_data[15:0]) << {adr[1], 4'b0000};
				lane_be  = 4'b0011 << {adr[1], 1'b0};
			end
			ls_w: begin
				st_wdata = st_data;
				lane_be  = 4'b1111;
			end
			default: begin
				// unsigned codes are load only
				st_wdata = '0;
				lane_be  = 4'b0000;
			end
		endcase
	end

	assign st_we = cmd_st ? lane_be : 4'b0000;

	// top two address bits pick the IO region
	assign is_io = (adr[xlen-1:xlen-2] == io_region);

	assign st_we_mem = st_we & {4{~is_io}};
	assign st_we_io  = st_we & {4{is_io}};

endmodule

// ==== design/data_1r1w.sv ====
/*
 * data_1r1w
 *   data RAM, one registered read port and one byte-writable write port
 */

module data_1r1w (
	input  logic                           clk,
	input  logic [rv_mem_pkg::ram_aw-1:0]  ram_radr,
	output logic [rv_mem_pkg::xlen-1:0]    ram_rdata,
	input  logic [rv_mem_pkg::ram_aw-1:0]  ram_wadr,
	input  logic [rv_mem_pkg::xlen-1:0]    ram_wdata,
	input  logic [3:0]                     ram_wen
);
	import rv_mem_pkg::*;

	localparam int depth = 1 << ram_aw;

	logic [xlen-1:0] mem [0:depth-1];

	// per-byte write
	always_ff @(posedge clk) begin
		for (int i = 0; i < 4; i++) begin
			if (ram_wen[i]) begin
				mem[ram_wadr][i*8 +: 8] <= ram_wdata[i*8 +: 8];
			end
		end
	end

	// read sees the old word on a same-address write
	always_ff @(posedge clk) begin
		ram_rdata <= mem[ram_radr];
	end

endmodule

// ==== design/ma_stage.sv ====
/*
 * ma_stage
 *   memory access stage: store path, IO port, RAM access, load hold and MA/WB register
 */

module ma_stage (
	input  logic                           clk,
	input  logic                           rst_n,
	// from execute
	input  logic                           cmd_ld,
	input  logic                           cmd_st,
	input  logic                           wbk_rd_reg,
	input  rv_mem_pkg::ldst_code_e         ldst_code,
	input  logic [rv_mem_pkg::reg_aw-1:0]  rd_adr,
	input  logic [rv_mem_pkg::xlen-1:0]    rd_data,
	input  logic [rv_mem_pkg::xlen-1:0]    st_data,
	// pipeline control
	input  logic                           stall,
	input  logic                           rst_pipe,
	// debug access
	input  logic [rv_mem_pkg::ram_aw-1:0]  dbg_radr,
	input  logic [rv_mem_pkg::ram_aw-1:0]  dbg_wadr,
	input  logic [rv_mem_pkg::xlen-1:0]    dbg_wdata,
	input  logic                           dbg_wen,
	input  logic                           dbg_rsel,
	output logic [rv_mem_pkg::xlen-1:0]    dbg_rdata,
	// IO store port
	output logic [3:0]                     io_we,
	output logic [rv_mem_pkg::io_aw-1:0]   io_adr,
	output logic [rv_mem_pkg::xlen-1:0]    io_wdata,
	// to write-back
	output logic                           cmd_ld_wb,
	output logic                           wbk_rd_reg_wb,
	output rv_mem_pkg::ldst_code_e         ld_code_wb,
	output logic [rv_mem_pkg::reg_aw-1:0]  rd_adr_wb,
	output logic [rv_mem_pkg::xlen-1:0]    rd_data_wb,
	output logic [rv_mem_pkg::xlen-1:0]    ld_data_wb
);
	import rv_mem_pkg::*;

	logic [xlen-1:0]   st_wdata;
	logic [3:0]        st_we_mem;
	logic [3:0]        st_we_io;
	logic [ram_aw-1:0] ram_radr;
	logic [ram_aw-1:0] ram_wadr;
	logic [xlen-1:0]   ram_wdata;
	logic [3:0]        ram_wen;
	logic [xlen-1:0]   ram_rdata;
	logic              stall_dly;
	logic              stall_1shot;
	logic [xlen-1:0]   ld_data_hold;

	store_align i_store_align (
		.cmd_st    (cmd_st),
		.ldst_code (ldst_code),
		.adr       (rd_data),
		.st_data   (st_data),
		.st_wdata  (st_wdata),
		.st_we_mem (st_we_mem),
		.st_we_io  (st_we_io)
	);

	assign io_we    = st_we_io;
	assign io_adr   = rd_data[io_aw+1:2];
	assign io_wdata = st_wdata;

	// debug port wins over the pipeline
	assign ram_radr  = dbg_rsel ? dbg_radr : rd_data[ram_aw+1:2];
	assign ram_wadr  = dbg_wen ? dbg_wadr : rd_data[ram_aw+1:2];
	assign ram_wdata = dbg_wen ? dbg_wdata : st_wdata;
	assign ram_wen   = dbg_wen ? 4'b1111 : st_we_mem;

	data_1r1w i_data_1r1w (
		.clk       (clk),
		.ram_radr  (ram_radr),
		.ram_rdata (ram_rdata),
		.ram_wadr  (ram_wadr),
		.ram_wdata (ram_wdata),
		.ram_wen   (ram_wen)
	);

	assign dbg_rdata = ram_rdata;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			stall_dly <= 1'b0;
		end else begin
			stall_dly <= stall;
		end
	end

	// first cycle of a stall
	assign stall_1shot = stall & ~stall_dly;

	// keep the first-cycle read data while stalled
	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ld_data_hold <= '0;
		end else if (rst_pipe) begin
			ld_data_hold <= '0;
		end else if (stall_1shot) begin
			ld_data_hold <= ram_rdata;
		end
	end

	assign ld_data_wb = stall_dly ? ld_data_hold : ram_rdata;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			cmd_ld_wb     <= 1'b0;
			wbk_rd_reg_wb <= 1'b0;
			ld_code_wb    <= ls_b;
			rd_adr_wb     <= '0;
			rd_data_wb    <= '0;
		end else if (rst_pipe) begin
			cmd_ld_wb     <= 1'b0;
			wbk_rd_reg_wb <= 1'b0;
			ld_code_wb    <= ls_b;
			rd_adr_wb     <= '0;
			rd_data_wb    <= '0;
		end else if (!stall) begin
			cmd_ld_wb     <= cmd_ld;
			wbk_rd_reg_wb <= wbk_rd_reg;
			ld_code_wb    <= ldst_code;
			rd_adr_wb     <= rd_adr;
			rd_data_wb    <= rd_data;
		end
	end

endmodule

// ==== design/wb_stage.sv ====
/*
 * wb_stage
 *   write-back: load lane select with sign or zero extension, register write port
 */

module wb_stage (
	input  logic                           cmd_ld_wb,
	input  logic                           wbk_rd_reg_wb,
	input  rv_mem_pkg::ldst_code_e         ld_code_wb,
	input  logic [rv_mem_pkg::reg_aw-1:0]  rd_adr_wb,
	input  logic [rv_mem_pkg::xlen-1:0]    rd_data_wb,
	input  logic [rv_mem_pkg::xlen-1:0]    ld_data_wb,
	output logic                           reg_we,
	output logic [rv_mem_pkg::reg_aw-1:0]  reg_wadr,
	output logic [rv_mem_pkg::xlen-1:0]    reg_wdata
);
	import rv_mem_pkg::*;

	logic [1:0]      ofs;
	logic [7:0]      ld_byte;
	logic [15:0]     ld_half;
	logic [xlen-1:0] ld_val;

	// low bits of the load address
	assign ofs = rd_data_wb[1:0];

	assign ld_byte = ld_data_wb[{ofs, 3'b000} +: 8];
	assign ld_half = ofs[1] ? ld_data_wb[31:16] : ld_data_wb[15:0];

	always_comb begin
		case (ld_code_wb)
			ls_b: begin
				ld_val = {{(xlen-8){ld_byte[7]}}, ld_byte};
			end
			ls_bu: begin
				ld_val = {{(xlen-8){1'b0}}, ld_byte};
			end
			ls_h: begin
				ld_val = {{(xlen-16){ld_half[15]}}, ld_half};
			end
			ls_hu: begin
				ld_val = {{(xlen-16){1'b0}}, ld_half};
			end
			default: begin
				ld_val = ld_data_wb;
			end
		endcase
	end

	assign reg_wdata = cmd_ld_wb ? ld_val : rd_data_wb;
	assign reg_wadr  = rd_adr_wb;

	// x0 is never written
	assign reg_we = wbk_rd_reg_wb & (rd_adr_wb != '0);

endmodule

// ==== design/mem_wb_top.sv ====
/*
 * mem_wb_top
 *   memory access, data RAM and write-back of the RV32I back end
 */

module mem_wb_top (
	input  logic                           clk,
	input  logic                           rst_n,
	input  logic                           cmd_ld,
	input  logic                           cmd_st,
	input  rv_mem_pkg::ldst_code_e         ldst_code,
	input  logic [rv_mem_pkg::reg_aw-1:0]  rd_adr,
	input  logic [rv_mem_pkg::xlen-1:0]    rd_data,
	input  logic                           wbk_rd_reg,
	input  logic [rv_mem_pkg::xlen-1:0]    st_data,
	input  logic                           stall,
	input  logic                           rst_pipe,
	input  logic [rv_mem_pkg::ram_aw-1:0]  dbg_radr,
	input  logic [rv_mem_pkg::ram_aw-1:0]  dbg_wadr,
	input  logic [rv_mem_pkg::xlen-1:0]    dbg_wdata,
	input  logic                           dbg_wen,
	input  logic                           dbg_rsel,
	output logic [rv_mem_pkg::xlen-1:0]    dbg_rdata,
	output logic                           reg_we,
	output logic [rv_mem_pkg::reg_aw-1:0]  reg_wadr,
	output logic [rv_mem_pkg::xlen-1:0]    reg_wdata,
	output logic [3:0]                     io_we,
	output logic [rv_mem_pkg::io_aw-1:0]   io_adr,
	output logic [rv_mem_pkg::xlen-1:0]    io_wdata
);
	import rv_mem_pkg::*;

	// MA to WB
	logic              cmd_ld_wb;
	logic              wbk_rd_reg_wb;
	ldst_code_e        ld_code_wb;
	logic [reg_aw-1:0] rd_adr_wb;
	logic [xlen-1:0]   rd_data_wb;
	logic [xlen-1:0]   ld_data_wb;

	ma_stage i_ma_stage (
		.clk           (clk),
		.rst_n         (rst_n),
		.cmd_ld        (cmd_ld),
		.cmd_st        (cmd_st),
		.wbk_rd_reg    (wbk_rd_reg),
		.ldst_code     (ldst_code),
		.rd_adr        (rd_adr),
		.rd_data       (rd_data),
		.st_data       (st_data),
		.stall         (stall),
		.rst_pipe      (rst_pipe),
		.dbg_radr      (dbg_radr),
		.dbg_wadr      (dbg_wadr),
		.dbg_wdata     (dbg_wdata),
		.dbg_wen       (dbg_wen),
		.dbg_rsel      (dbg_rsel),
		.dbg_rdata     (dbg_rdata),
		.io_we         (io_we),
		.io_adr        (io_adr),
		.io_wdata      (io_wdata),
		.cmd_ld_wb     (cmd_ld_wb),
		.wbk_rd_reg_wb (wbk_rd_reg_wb),
		.ld_code_wb    (ld_code_wb),
		.rd_adr_wb     (rd_adr_wb),
		.rd_data_wb    (rd_data_wb),
		.ld_data_wb    (ld_data_wb)
	);

	wb_stage i_wb_stage (
		.cmd_ld_wb     (cmd_ld_wb),
		.wbk_rd_reg_wb (wbk_rd_reg_wb),
		.ld_code_wb    (ld_code_wb),
		.rd_adr_wb     (rd_adr_wb),
		.rd_data_wb    (rd_data_wb),
		.ld_data_wb    (ld_data_wb),
		.reg_we        (reg_we),
		.reg_wadr      (reg_wadr),
		.reg_wdata     (reg_wdata)
	);

endmodule

// ==== bench/tb_mem_wb.sv ====
/*
 * tb_mem_wb
 *   table-driven testbench for the memory access and write-back stages
 */

module tb_mem_wb;
	import rv_mem_pkg::*;

	localparam int period   = 100;
	localparam int words    = 16;
	localparam int max_rows = 40;

	logic              clk;
	logic              rst_n;
	logic              cmd_ld;
	logic              cmd_st;
	ldst_code_e        ldst_code;
	logic [reg_aw-1:0] rd_adr;
	logic [xlen-1:0]   rd_data;
	logic              wbk_rd_reg;
	logic [xlen-1:0]   st_data;
	logic              stall;
	logic              rst_pipe;
	logic [ram_aw-1:0] dbg_radr;
	logic [ram_aw-1:0] dbg_wadr;
	logic [xlen-1:0]   dbg_wdata;
	logic              dbg_wen;
	logic              dbg_rsel;
	logic [xlen-1:0]   dbg_rdata;
	logic              reg_we;
	logic [reg_aw-1:0] reg_wadr;
	logic [xlen-1:0]   reg_wdata;
	logic [3:0]        io_we;
	logic [io_aw-1:0]  io_adr;
	logic [xlen-1:0]   io_wdata;

	// stimulus table, one array per column
	logic              t_ld    [0:max_rows-1];
	logic              t_st    [0:max_rows-1];
	ldst_code_e        t_code  [0:max_rows-1];
	logic [xlen-1:0]   t_adr   [0:max_rows-1];
	logic [xlen-1:0]   t_sdata [0:max_rows-1];
	logic [reg_aw-1:0] t_rd    [0:max_rows-1];
	logic              t_wbk   [0:max_rows-1];
	logic              t_stall [0:max_rows-1];
	int                n_rows;

	// memory model and expected write-back
	logic [xlen-1:0]   model [0:words-1];
	logic              exp_we;
	logic [reg_aw-1:0] exp_wadr;
	logic [xlen-1:0]   exp_wdata;
	logic [3:0]        lanes;
	logic [xlen-1:0]   aligned;
	logic              io_hit;
	int unsigned       seed;

	mem_wb_top i_dut (.*);

	initial begin
		clk = 1'b0;
		forever #(period / 2) clk = ~clk;
	end

	task automatic fail_now(input string what);
		$display("%s", what);
		$display("TESTBENCH FAILED");
		$fatal(1);
	endtask

	task automatic value_error(input string name, input logic [xlen-1:0] got,
		input logic [xlen-1:0] want);
		fail_now($sformatf("error %s: got %h, expected %h", name, got, want));
	endtask

	task automatic check_reg(input logic we, input logic [reg_aw-1:0] wadr,
		input logic [xlen-1:0] wdata);
		if (reg_we !== we) value_error("reg_we", xlen'(reg_we), xlen'(we));
		if (reg_wadr !== wadr) value_error("reg_wadr", xlen'(reg_wadr), xlen'(wadr));
		if (reg_wdata !== wdata) value_error("reg_wdata", reg_wdata, wdata);
	endtask

	// data lanes without an enable are don't care
	task automatic expect_io(input logic [3:0] we, input logic [io_aw-1:0] adr,
		input logic [xlen-1:0] wdata);
		logic [xlen-1:0] mask;
		mask = {{8{we[3]}}, {8{we[2]}}, {8{we[1]}}, {8{we[0]}}};
		if (io_we !== we) value_error("io_we", xlen'(io_we), xlen'(we));
		if (we != 4'b0000 && io_adr !== adr) value_error("io_adr", xlen'(io_adr), xlen'(adr));
		if ((io_wdata & mask) !== (wdata & mask)) begin
			value_error("io_wdata", io_wdata & mask, wdata & mask);
		end
	endtask

	task automatic verify_word(input logic [ram_aw-1:0] adr, input logic [xlen-1:0] word);
		if (dbg_rdata !== word) begin
			fail_now($sformatf("error dbg_rdata at word %h: got %h, expected %h",
				adr, dbg_rdata, word));
		end
	endtask

	// RV32I load extension rules
	function automatic logic [xlen-1:0] load_value(input ldst_code_e code,
		input logic [xlen-1:0] word, input logic [1:0] ofs);
		logic [7:0]  b;
		logic [15:0] h;
		b = 8'(word >> (8 * ofs));
		h = 16'(word >> (16 * ofs[1]));
		case (code)
			ls_b:    return {{24{b[7]}}, b};
			ls_bu:   return {24'h0, b};
			ls_h:    return {{16{h[15]}}, h};
			ls_hu:   return {16'h0, h};
			default: return word;
		endcase
	endfunction

	task automatic store_lanes(input ldst_code_e code, input logic [1:0] ofs,
		input logic [xlen-1:0] data, output logic [3:0] be, output logic [xlen-1:0] wdata);
		be    = 4'b0000;
		wdata = '0;
		case (code)
			ls_b: begin
				be[ofs]             = 1'b1;
				wdata[8*ofs +: 8]   = data[7:0];
			end
			ls_h: begin
				be[2*ofs[1] +: 2]     = 2'b11;
				wdata[16*ofs[1] +: 16] = data[15:0];
			end
			ls_w: begin
				be    = 4'b1111;
				wdata = data;
			end
			default: ;
		endcase
	endtask

	task automatic add_row(input logic ld, input logic st, input ldst_code_e code,
		input logic [xlen-1:0] adr, input logic [xlen-1:0] sdata,
		input logic [reg_aw-1:0] rd, input logic wbk, input logic stl);
		t_ld[n_rows]    = ld;
		t_st[n_rows]    = st;
		t_code[n_rows]  = code;
		t_adr[n_rows]   = adr;
		t_sdata[n_rows] = sdata;
		t_rd[n_rows]    = rd;
		t_wbk[n_rows]   = wbk;
		t_stall[n_rows] = stl;
		n_rows++;
	endtask

	task automatic build_table();
		n_rows = 0;
		// every load code at every legal offset of word 1
		add_row(1'b1, 1'b0, ls_b,  32'h0000_0004, 32'h0, 5'd1,  1'b1, 1'b0);
		add_row(1'b1, 1'b0, ls_b,  32'h0000_0005, 32'h0, 5'd2,  1'b1, 1'b0);
		add_row(1'b1, 1'b0, ls_b,  32'h0000_0006, 32'h0, 5'd3,  1'b1, 1'b0);
		add_row(1'b1, 1'b0, ls_b,  32'h0000_0007, 32'h0, 5'd4,  1'b1, 1'b0);
		add_row(1'b1, 1'b0, ls_bu, 32'h0000_0004, 32'h0, 5'd5,  1'b1, 1'b0);
		add_row(1'b1, 1'b0, ls_bu, 32'h0000_0005, 32'h0, 5'd6,  1'b1, 1'b0);
		add_row(1'b1, 1'b0, ls_bu, 32'h0000_0006, 32'h0, 5'd7,  1'b1, 1'b0);
		add_row(1'b1, 1'b0, ls_bu, 32'h0000_0007, 32'h0, 5'd8,  1'b1, 1'b0);
		add_row(1'b1, 1'b0, ls_h,  32'h0000_0004, 32'h0, 5'd9,  1'b1, 1'b0);
		add_row(1'b1, 1'b0, ls_h,  32'h0000_0006, 32'h0, 5'd10, 1'b1, 1'b0);
		add_row(1'b1, 1'b0, ls_hu, 32'h0000_0004, 32'h0, 5'd11, 1'b1, 1'b0);
		add_row(1'b1, 1'b0, ls_hu, 32'h0000_0006, 32'h0, 5'd12, 1'b1, 1'b0);
		add_row(1'b1, 1'b0, ls_w,  32'h0000_0004, 32'h0, 5'd13, 1'b1, 1'b0);
		// x0 destination, then an ALU result
		add_row(1'b1, 1'b0, ls_w,  32'h0000_0008, 32'h0, 5'd0,  1'b1, 1'b0);
		add_row(1'b0, 1'b0, ls_w,  32'hdead_beef, 32'h0, 5'd14, 1'b1, 1'b0);
		// partial and full stores, checked by loads
		add_row(1'b0, 1'b1, ls_b,  32'h0000_000d, 32'h1234_5680, 5'd0, 1'b0, 1'b0);
		add_row(1'b0, 1'b1, ls_h,  32'h0000_000e, 32'hffff_8001, 5'd0, 1'b0, 1'b0);
		add_row(1'b1, 1'b0, ls_w,  32'h0000_000c, 32'h0, 5'd15, 1'b1, 1'b0);
		add_row(1'b1, 1'b0, ls_b,  32'h0000_000d, 32'h0, 5'd16, 1'b1, 1'b0);
		add_row(1'b0, 1'b1, ls_w,  32'h0000_0010, 32'ha5a5_5a5a, 5'd0, 1'b0, 1'b0);
		add_row(1'b1, 1'b0, ls_h,  32'h0000_0012, 32'h0, 5'd19, 1'b1, 1'b0);
		// IO stores leave word 2 alone
		add_row(1'b0, 1'b1, ls_w,  32'hc000_0008, 32'h0bad_f00d, 5'd0, 1'b0, 1'b0);
		add_row(1'b0, 1'b1, ls_b,  32'hc000_0ffd, 32'h0000_0077, 5'd0, 1'b0, 1'b0);
		add_row(1'b0, 1'b1, ls_h,  32'hc000_0102, 32'h1111_beef, 5'd0, 1'b0, 1'b0);
		add_row(1'b1, 1'b0, ls_w,  32'h0000_0008, 32'h0, 5'd20, 1'b1, 1'b0);
		// load, then the next load held in MA for three stalled cycles
		add_row(1'b1, 1'b0, ls_w,  32'h0000_0014, 32'h0, 5'd21, 1'b1, 1'b0);
		add_row(1'b1, 1'b0, ls_b,  32'h0000_001b, 32'h0, 5'd22, 1'b1, 1'b1);
		add_row(1'b1, 1'b0, ls_b,  32'h0000_001b, 32'h0, 5'd22, 1'b1, 1'b1);
		add_row(1'b1, 1'b0, ls_b,  32'h0000_001b, 32'h0, 5'd22, 1'b1, 1'b1);
		add_row(1'b1, 1'b0, ls_b,  32'h0000_001b, 32'h0, 5'd22, 1'b1, 1'b0);
	endtask

	task automatic drive_idle();
		cmd_ld     = 1'b0;
		cmd_st     = 1'b0;
		ldst_code  = ls_w;
		rd_adr     = '0;
		rd_data    = '0;
		wbk_rd_reg = 1'b0;
		st_data    = '0;
		stall      = 1'b0;
	endtask

	task automatic read_back_ram();
		dbg_rsel = 1'b1;
		for (int i = 0; i <= words; i++) begin
			@(negedge clk);
			if (i > 0) begin
				verify_word(ram_aw'(i - 1), model[i-1]);
			end
			if (i < words) begin
				dbg_radr = ram_aw'(i);
			end
		end
		dbg_rsel = 1'b0;
	endtask

	task automatic wait_reg_we(input int max_cycles);
		int n;
		n = 0;
		do begin
			@(negedge clk);
			n++;
		end while (reg_we !== 1'b1 && n < max_cycles);
		if (reg_we !== 1'b1) begin
			fail_now("register write did not appear before the timeout");
		end
	endtask

	initial begin
		seed      = 32'h95f2_ff5a;
		void'($urandom(seed));
		rst_n     = 1'b0;
		rst_pipe  = 1'b0;
		dbg_radr  = '0;
		dbg_wadr  = '0;
		dbg_wdata = '0;
		dbg_wen   = 1'b0;
		dbg_rsel  = 1'b0;
		exp_we    = 1'b0;
		exp_wadr  = '0;
		exp_wdata = '0;
		drive_idle();
		for (int i = 0; i < words; i++) begin
			model[i] = $urandom;
		end
		build_table();
		repeat (3) @(negedge clk);
		rst_n = 1'b1;

		// quiet outputs right after reset
		@(negedge clk);
		check_reg(1'b0, '0, '0);
		expect_io(4'b0000, '0, '0);

		for (int i = 0; i < words; i++) begin
			@(negedge clk);
			dbg_wen   = 1'b1;
			dbg_wadr  = ram_aw'(i);
			dbg_wdata = model[i];
		end
		@(negedge clk);
		dbg_wen = 1'b0;
		read_back_ram();

		for (int i = 0; i < n_rows; i++) begin
			@(negedge clk);
			check_reg(exp_we, exp_wadr, exp_wdata);
			cmd_ld     = t_ld[i];
			cmd_st     = t_st[i];
			ldst_code  = t_code[i];
			rd_data    = t_adr[i];
			st_data    = t_sdata[i];
			rd_adr     = t_rd[i];
			wbk_rd_reg = t_wbk[i];
			stall      = t_stall[i];
			store_lanes(t_code[i], t_adr[i][1:0], t_sdata[i], lanes, aligned);
			io_hit = t_st[i] && (t_adr[i][31:30] == io_region);
			// late in the cycle the WB outputs hold and the IO port is live
			#(period / 4);
			check_reg(exp_we, exp_wadr, exp_wdata);
			expect_io(io_hit ? lanes : 4'b0000, t_adr[i][11:2], aligned);
			if (!t_stall[i]) begin
				exp_we    = t_wbk[i] && (t_rd[i] != '0);
				exp_wadr  = t_rd[i];
				exp_wdata = t_ld[i] ?
					load_value(t_code[i], model[t_adr[i][5:2]], t_adr[i][1:0]) : t_adr[i];
			end
			if (t_st[i] && !io_hit) begin
				for (int l = 0; l < 4; l++) begin
					if (lanes[l]) model[t_adr[i][5:2]][8*l +: 8] = aligned[8*l +: 8];
				end
			end
		end

		// pipeline flush
		@(negedge clk);
		check_reg(exp_we, exp_wadr, exp_wdata);
		drive_idle();
		wbk_rd_reg = 1'b1;
		rd_adr     = 5'd17;
		rd_data    = 32'h2468_ace0;
		wait_reg_we(4);
		check_reg(1'b1, 5'd17, 32'h2468_ace0);
		rst_pipe = 1'b1;
		@(negedge clk);
		check_reg(1'b0, '0, '0);
		rst_pipe = 1'b0;
		drive_idle();

		read_back_ram();
		$display("TESTBENCH PASSED");
		$finish;
	end

endmodule

// ==== sources.f ====
design/rv_mem_pkg.sv
design/store_align.sv
design/data_1r1w.sv
design/ma_stage.sv
design/wb_stage.sv
design/mem_wb_top.sv
bench/tb_mem_wb.sv

// ==== Bender.yml ====
package:
  name: mem_wb

sources:
  - files:
      - design/rv_mem_pkg.sv
      - design/store_align.sv
      - design/data_1r1w.sv
      - design/ma_stage.sv
      - design/wb_stage.sv
      - design/mem_wb_top.sv
  - target: test
    files:
      - bench/tb_mem_wb.sv
